//--- Makefile
# Verilator build and run of the memory request hub testbench

VERILATOR   ?= verilator
TOP         ?= mreq_hub_tb
FILELIST    ?= mreq_hub.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert -j 0
ERROR_LIMIT ?= 100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS ERROR_LIMIT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/axil_req_arbiter.sv
/*
 * Round-robin arbiter over the request queue heads, driving one AXI4-Lite
 * master with a single transaction outstanding and returning each
 * response to the port that issued it
 */
`timescale 1ns/1ps
`include "mreq_settings.svh"

module axil_req_arbiter import mreq_pkg::*; #(
    localparam int NUM_PORTS = `MREQ_NUM_PORTS
)(
    input  logic                      clk,
    input  logic                      i_rst_n,

    // Queue heads
    input  logic [NUM_PORTS-1:0]      i_head_valid,
    input  mreq_req_t [NUM_PORTS-1:0] i_head,
    output logic [NUM_PORTS-1:0]      o_pop,

    // AXI4-Lite master
    output logic                      o_awvalid,
    input  logic                      i_awready,
    output axil_addr_t                o_aw,
    output logic                      o_wvalid,
    input  logic                      i_wready,
    output axil_wdata_t               o_w,
    input  logic                      i_bvalid,
    output logic                      o_bready,
    input  axil_bresp_t               i_b,
    output logic                      o_arvalid,
    input  logic                      i_arready,
    output axil_addr_t                o_ar,
    input  logic                      i_rvalid,
    output logic                      o_rready,
    input  axil_rdata_t               i_r,

    // Responses to the requesters
    output logic [NUM_PORTS-1:0]      o_rsp_valid,
    output mreq_rsp_t [NUM_PORTS-1:0] o_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP
    } state_e;

    // Unprivileged, secure, data access
    localparam logic [2:0] AXIL_PROT = 3'b000;

    state_e               state_r;
    state_e               state_next;
    port_idx_t            prio_r;
    port_idx_t            grant_idx;
    logic                 grant_found;
    logic                 take;
    mreq_req_t            hold_req_r;
    port_idx_t            hold_port_r;
    logic                 aw_done_r;
    logic                 w_done_r;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 ar_hs;
    logic                 b_hs;
    logic                 r_hs;
    logic                 addr_phase_done;
    logic [NUM_PORTS-1:0] rsp_valid_r;
    mreq_rsp_t            rsp_r;

    function automatic port_idx_t next_port(input port_idx_t p);
        return (int'(p) == NUM_PORTS - 1) ? '0 : p + 1'b1;
    endfunction

    // Search from the priority pointer for the first waiting head
    always_comb begin
        port_idx_t cand;
        grant_found = 1'b0;
        grant_idx   = prio_r;
        cand        = prio_r;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (!grant_found && i_head_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
            cand = next_port(cand);
        end
    end

    assign take = (state_r == ST_IDLE) & grant_found;

    always_comb begin
        o_pop = '0;
        if (take) begin
            o_pop[grant_idx] = 1'b1;
        end
    end

    // Address and data phase, AW and W each drop on their own handshake
    assign o_awvalid = (state_r == ST_ADDR) & hold_req_r.write & ~aw_done_r;
    assign o_wvalid  = (state_r == ST_ADDR) & hold_req_r.write & ~w_done_r;
    assign o_arvalid = (state_r == ST_ADDR) & ~hold_req_r.write;
    assign o_bready  = 1'b1;
    assign o_rready  = 1'b1;

    assign o_aw = '{addr: hold_req_r.addr, prot: AXIL_PROT};
    assign o_ar = '{addr: hold_req_r.addr, prot: AXIL_PROT};
    assign o_w  = '{data: hold_req_r.wdata, strb: '1};

    assign aw_hs = o_awvalid & i_awready;
    assign w_hs  = o_wvalid & i_wready;
    assign ar_hs = o_arvalid & i_arready;
    assign b_hs  = (state_r == ST_RESP) & hold_req_r.write & i_bvalid & o_bready;
    assign r_hs  = (state_r == ST_RESP) & ~hold_req_r.write & i_rvalid & o_rready;

    assign addr_phase_done = hold_req_r.write ? ((aw_done_r | aw_hs) & (w_done_r | w_hs))
                                              : ar_hs;

    always_comb begin
        state_next = state_r;
        case (state_r)
            ST_IDLE: if (grant_found) state_next = ST_ADDR;
            ST_ADDR: if (addr_phase_done) state_next = ST_RESP;
            ST_RESP: if (b_hs | r_hs) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= ST_IDLE;
            prio_r      <= '0;
            aw_done_r   <= 1'b0;
            w_done_r    <= 1'b0;
            rsp_valid_r <= '0;
        end else begin
            state_r <= state_next;
            // The port after the one just granted goes first next time
            if (take) begin
                prio_r <= next_port(grant_idx);
            end
            aw_done_r   <= (state_r == ST_ADDR) & (aw_done_r | aw_hs);
            w_done_r    <= (state_r == ST_ADDR) & (w_done_r | w_hs);
            rsp_valid_r <= '0;
            if (b_hs | r_hs) begin
                rsp_valid_r[hold_port_r] <= 1'b1;
            end
        end
    end

    // Holding register for the granted request and the response word
    always_ff @(posedge clk) begin
        if (take) begin
            hold_req_r  <= i_head[grant_idx];
            hold_port_r <= grant_idx;
        end
        if (b_hs) begin
            rsp_r.rdata <= '0;
            rsp_r.err   <= (i_b != AXIL_OKAY);
        end else if (r_hs) begin
            // Error responses return no data
            rsp_r.rdata <= (i_r.resp != AXIL_OKAY) ? '0 : i_r.data;
            rsp_r.err   <= (i_r.resp != AXIL_OKAY);
        end
    end

    // Every port sees the response word, only the owner gets the pulse
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            o_rsp[p] = rsp_r;
        end
    end

    assign o_rsp_valid = rsp_valid_r;

endmodule

//--- hw/mreq_hub.sv
/*
 * Memory request hub top level: one request queue per requester port
 * feeding the round-robin AXI4-Lite arbiter
 */
`timescale 1ns/1ps
`include "mreq_settings.svh"

module mreq_hub import mreq_pkg::*; #(
    parameter  int QUEUE_DEPTH = `MREQ_QUEUE_DEPTH,
    localparam int NUM_PORTS   = `MREQ_NUM_PORTS
)(
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_flush,

    // Requester ports
    input  logic [NUM_PORTS-1:0]      i_req_valid,
    input  mreq_req_t [NUM_PORTS-1:0] i_req,
    output logic [NUM_PORTS-1:0]      o_req_ready,
    output logic [NUM_PORTS-1:0]      o_rsp_valid,
    output mreq_rsp_t [NUM_PORTS-1:0] o_rsp,

    // AXI4-Lite master
    output logic                      o_awvalid,
    input  logic                      i_awready,
    output axil_addr_t                o_aw,
    output logic                      o_wvalid,
    input  logic                      i_wready,
    output axil_wdata_t               o_w,
    input  logic                      i_bvalid,
    output logic                      o_bready,
    input  axil_bresp_t               i_b,
    output logic                      o_arvalid,
    input  logic                      i_arready,
    output axil_addr_t                o_ar,
    input  logic                      i_rvalid,
    output logic                      o_rready,
    input  axil_rdata_t               i_r
);

    logic [NUM_PORTS-1:0]      head_valid;
    mreq_req_t [NUM_PORTS-1:0] head;
    logic [NUM_PORTS-1:0]      pop;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        req_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_req_queue (
            .clk          (clk),
            .i_rst_n      (i_rst_n),
            .i_flush      (i_flush),
            .i_req_valid  (i_req_valid[p]),
            .i_req        (i_req[p]),
            .o_req_ready  (o_req_ready[p]),
            .o_head_valid (head_valid[p]),
            .o_head       (head[p]),
            .i_pop        (pop[p])
        );
    end

    axil_req_arbiter i_axil_req_arbiter (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_head_valid (head_valid),
        .i_head       (head),
        .o_pop        (pop),
        .o_awvalid    (o_awvalid),
        .i_awready    (i_awready),
        .o_aw         (o_aw),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .o_w          (o_w),
        .i_bvalid     (i_bvalid),
        .o_bready     (o_bready),
        .i_b          (i_b),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .o_ar         (o_ar),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .i_r          (i_r),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp)
    );

endmodule

//--- hw/mreq_pkg.sv
/*
 * Shared types of the memory request hub: requester request and
 * response words, AXI4-Lite channel payloads and the port index
 */
`include "mreq_settings.svh"

package mreq_pkg;

    // Index of a requester port
    typedef logic [((`MREQ_NUM_PORTS > 1) ? $clog2(`MREQ_NUM_PORTS) : 1)-1:0] port_idx_t;

    // One request as queued for a port
    typedef struct packed {
        logic                        write;
        logic [`MREQ_ADDR_WIDTH-1:0] addr;
        logic [`MREQ_DATA_WIDTH-1:0] wdata;
    } mreq_req_t;

    // Response returned to the issuing port, rdata is zero for writes
    typedef struct packed {
        logic [`MREQ_DATA_WIDTH-1:0] rdata;
        logic                        err;
    } mreq_rsp_t;

    // AXI response codes
    typedef enum logic [1:0] {
        AXIL_OKAY   = 2'b00,
        AXIL_EXOKAY = 2'b01,
        AXIL_SLVERR = 2'b10,
        AXIL_DECERR = 2'b11
    } axil_resp_e;

    // AW and AR payload
    typedef struct packed {
        logic [`MREQ_ADDR_WIDTH-1:0] addr;
        logic [2:0]                  prot;
    } axil_addr_t;

    // W payload
    typedef struct packed {
        logic [`MREQ_DATA_WIDTH-1:0]   data;
        logic [`MREQ_DATA_WIDTH/8-1:0] strb;
    } axil_wdata_t;

    // R payload
    typedef struct packed {
        logic [`MREQ_DATA_WIDTH-1:0] data;
        axil_resp_e                  resp;
    } axil_rdata_t;

    // B carries only the response code
    typedef axil_resp_e axil_bresp_t;

endpackage

//--- hw/mreq_settings.svh
/*
 * Build-time sizes for the memory request hub: queue depth,
 * AXI4-Lite address and data widths and the number of requester ports
 */
`ifndef MREQ_SETTINGS_SVH
`define MREQ_SETTINGS_SVH

// Entries in each requester's circular request queue
`define MREQ_QUEUE_DEPTH 4

// Byte address and data widths on both the requester and bus sides
`define MREQ_ADDR_WIDTH 32
`define MREQ_DATA_WIDTH 32

// Requester ports sharing the single AXI4-Lite master
`define MREQ_NUM_PORTS 2

`endif

//--- hw/queue_ctrl.sv
/*
 * Circular queue control: head and tail pointers with wrap at any depth,
 * a free-entry down counter and registered full and empty flags
 */
`timescale 1ns/1ps

module queue_ctrl #(
    parameter  int QUEUE_DEPTH = 4,
    localparam int IDX_WIDTH   = (QUEUE_DEPTH == 1) ? 1 : $clog2(QUEUE_DEPTH),
    localparam int CNT_WIDTH   = $clog2(QUEUE_DEPTH + 1)
)(
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_incr_head,
    input  logic                 i_incr_tail,
    output logic [IDX_WIDTH-1:0] o_queue_head,
    output logic [IDX_WIDTH-1:0] o_queue_tail,
    output logic                 o_queue_full,
    output logic                 o_queue_empty
);

    logic [IDX_WIDTH-1:0] head_r;
    logic [IDX_WIDTH-1:0] tail_r;
    logic [IDX_WIDTH-1:0] head_next;
    logic [IDX_WIDTH-1:0] tail_next;
    logic [CNT_WIDTH-1:0] free_cnt_r;
    logic [CNT_WIDTH-1:0] free_cnt_next;
    logic                 full_r;
    logic                 empty_r;

    // Step a pointer by one, wrapping at the last entry
    function automatic logic [IDX_WIDTH-1:0] wrap_incr(input logic [IDX_WIDTH-1:0] ptr);
        return (ptr == IDX_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Flush overrides any pointer movement
    always_comb begin
        head_next = i_incr_head ? wrap_incr(head_r) : head_r;
        tail_next = i_incr_tail ? wrap_incr(tail_r) : tail_r;
        if (i_flush) begin
            head_next = '0;
            tail_next = '0;
        end
    end

    // Enqueue consumes a free entry and a pop returns one
    always_comb begin
        free_cnt_next = free_cnt_r;
        unique case ({i_incr_head, i_incr_tail})
            2'b01:   free_cnt_next = free_cnt_r - 1'b1;
            2'b10:   free_cnt_next = free_cnt_r + 1'b1;
            default: free_cnt_next = free_cnt_r;
        endcase
        if (i_flush) begin
            free_cnt_next = CNT_WIDTH'(QUEUE_DEPTH);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_r     <= '0;
            tail_r     <= '0;
            free_cnt_r <= CNT_WIDTH'(QUEUE_DEPTH);
            full_r     <= 1'b0;
            empty_r    <= 1'b1;
        end else begin
            head_r     <= head_next;
            tail_r     <= tail_next;
            free_cnt_r <= free_cnt_next;
            // Flags follow the counter's next value so they line up with it
            full_r     <= (free_cnt_next == '0);
            empty_r    <= (free_cnt_next == CNT_WIDTH'(QUEUE_DEPTH));
        end
    end

    assign o_queue_head  = head_r;
    assign o_queue_tail  = tail_r;
    assign o_queue_full  = full_r;
    assign o_queue_empty = empty_r;

endmodule

//--- hw/req_queue.sv
/*
 * Request queue for one requester port: entry storage indexed by the
 * pointers from queue_ctrl, a ready/valid enqueue side and a head/pop side
 */
`timescale 1ns/1ps
`include "mreq_settings.svh"

module req_queue import mreq_pkg::*; #(
    parameter  int QUEUE_DEPTH = `MREQ_QUEUE_DEPTH,
    localparam int IDX_WIDTH   = (QUEUE_DEPTH == 1) ? 1 : $clog2(QUEUE_DEPTH)
)(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_flush,

    // Enqueue side from the requester
    input  logic      i_req_valid,
    input  mreq_req_t i_req,
    output logic      o_req_ready,

    // Head side towards the arbiter
    output logic      o_head_valid,
    output mreq_req_t o_head,
    input  logic      i_pop
);

    logic [IDX_WIDTH-1:0] head_idx;
    logic [IDX_WIDTH-1:0] tail_idx;
    logic                 queue_full;
    logic                 queue_empty;
    logic                 push;
    logic                 pop;
    mreq_req_t            entries_r [QUEUE_DEPTH];

    // A push while full never happens because ready follows the full flag
    assign push = i_req_valid & o_req_ready;

    // Popping an empty queue would corrupt the free count
    assign pop = i_pop & ~queue_empty;

    queue_ctrl #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue_ctrl (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_incr_head   (pop),
        .i_incr_tail   (push),
        .o_queue_head  (head_idx),
        .o_queue_tail  (tail_idx),
        .o_queue_full  (queue_full),
        .o_queue_empty (queue_empty)
    );

    // Entry storage, written at the tail
    // A push in a flush cycle lands here but the pointers drop it
    always_ff @(posedge clk) begin
        if (push) begin
            entries_r[tail_idx] <= i_req;
        end
    end

    assign o_req_ready  = ~queue_full;
    assign o_head_valid = ~queue_empty;
    assign o_head       = entries_r[head_idx];

endmodule

//--- mreq_hub.f
+incdir+hw
hw/mreq_pkg.sv
hw/queue_ctrl.sv
hw/req_queue.sv
hw/axil_req_arbiter.sv
hw/mreq_hub.sv
verif/axil_mem_model.sv
verif/mreq_hub_chk.sv
verif/mreq_hub_tb.sv

//--- verif/axil_mem_model.sv
/*
 * AXI4-Lite slave memory for the testbench: 256 words from address zero,
 * SLVERR above that range, and a stall input that holds every ready low
 */
`timescale 1ns/1ps

module axil_mem_model import mreq_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_stall,
    input  logic        i_awvalid,
    output logic        o_awready,
    input  axil_addr_t  i_aw,
    input  logic        i_wvalid,
    output logic        o_wready,
    input  axil_wdata_t i_w,
    output logic        o_bvalid,
    input  logic        i_bready,
    output axil_bresp_t o_b,
    input  logic        i_arvalid,
    output logic        o_arready,
    input  axil_addr_t  i_ar,
    output logic        o_rvalid,
    input  logic        i_rready,
    output axil_rdata_t o_r
);

    localparam int MEM_WORDS = 256;

    logic [31:0] mem [MEM_WORDS];
    logic        aw_got_r;
    logic        w_got_r;
    logic [31:0] aw_addr_r;
    logic [31:0] w_data_r;

    function automatic logic in_range(input logic [31:0] addr);
        return addr < 32'(MEM_WORDS * 4);
    endfunction

    // Fill word mixes in every address bit so a wrong index shows up
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5eed_0000 ^ (32'(i) << 2);
        end
    end

    assign o_awready = ~i_stall & ~aw_got_r & ~o_bvalid;
    assign o_wready  = ~i_stall & ~w_got_r & ~o_bvalid;
    assign o_arready = ~i_stall & ~o_rvalid;

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            aw_got_r <= 1'b0;
            w_got_r  <= 1'b0;
            o_bvalid <= 1'b0;
            o_b      <= AXIL_OKAY;
            o_rvalid <= 1'b0;
            o_r      <= '0;
        end else begin
            if (i_awvalid && o_awready) begin
                aw_got_r  <= 1'b1;
                aw_addr_r <= i_aw.addr;
            end
            if (i_wvalid && o_wready) begin
                w_got_r  <= 1'b1;
                w_data_r <= i_w.data;
            end
            // The write commits once both address and data have arrived
            if (aw_got_r && w_got_r) begin
                aw_got_r <= 1'b0;
                w_got_r  <= 1'b0;
                o_bvalid <= 1'b1;
                o_b      <= in_range(aw_addr_r) ? AXIL_OKAY : AXIL_SLVERR;
            end else if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (i_arvalid && o_arready) begin
                o_rvalid <= 1'b1;
                if (in_range(i_ar.addr)) begin
                    o_r <= '{data: mem[i_ar.addr[9:2]], resp: AXIL_OKAY};
                end else begin
                    // Junk data, the hub has to zero it
                    o_r <= '{data: 32'hdead_beef, resp: AXIL_SLVERR};
                end
            end else if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (aw_got_r && w_got_r && in_range(aw_addr_r)) begin
            mem[aw_addr_r[9:2]] <= w_data_r;
        end
    end

endmodule

//--- verif/mreq_hub_chk.sv
/*
 * Concurrent assertions on the hub's AXI4-Lite master and requester ports
 */
`timescale 1ns/1ps
`include "mreq_settings.svh"

module mreq_hub_chk import mreq_pkg::*; #(
    localparam int NUM_PORTS = `MREQ_NUM_PORTS
)(
    input logic                 clk,
    input logic                 i_rst_n,
    input logic                 o_awvalid,
    input logic                 i_awready,
    input axil_addr_t           o_aw,
    input logic                 o_wvalid,
    input logic                 i_wready,
    input axil_wdata_t          o_w,
    input logic                 o_arvalid,
    input logic                 i_arready,
    input axil_addr_t           o_ar,
    input logic [NUM_PORTS-1:0] o_req_ready,
    input logic [NUM_PORTS-1:0] o_rsp_valid
);

    // Count of failed assertions, watched by the testbench
    int unsigned fail_cnt = 0;

    // A stalled channel keeps valid up and its payload unchanged
    a_aw_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_aw))
        else begin
            fail_cnt++;
            $error("AW valid or payload changed while stalled");
        end

    a_w_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_wvalid && !i_wready |=> o_wvalid && $stable(o_w))
        else begin
            fail_cnt++;
            $error("W valid or payload changed while stalled");
        end

    a_ar_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar))
        else begin
            fail_cnt++;
            $error("AR valid or payload changed while stalled");
        end

    // One transaction at a time, so a read and a write never overlap
    a_no_aw_ar: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_awvalid && o_arvalid))
        else begin
            fail_cnt++;
            $error("AW and AR valid together");
        end

    a_rsp_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(o_rsp_valid))
        else begin
            fail_cnt++;
            $error("Response pulse on more than one port");
        end

    a_ready_after_reset: assert property (@(posedge clk)
        $rose(i_rst_n) |-> &o_req_ready)
        else begin
            fail_cnt++;
            $error("Request ready low after reset");
        end

endmodule

//--- verif/mreq_hub_tb.sv
/*
 * Testbench for the memory request hub: clock, reset, watchdog,
 * response and bus monitors, and the directed tests
 */
`timescale 1ns/1ps
`include "mreq_settings.svh"

module mreq_hub_tb import mreq_pkg::*; ();

    localparam int NUM_PORTS = `MREQ_NUM_PORTS;
    localparam int DEPTH     = `MREQ_QUEUE_DEPTH;
    localparam int CLK_NS    = 10;
    localparam int MEM_BYTES = 1024;
    localparam int RAND_REQS = 60;
    // Requests issued by the tests, in the order they run
    localparam int TOTAL_REQS = 8 + (DEPTH + 1) + 2 * (2 * DEPTH + 1) + 3 + RAND_REQS;

    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    logic                      stall;
    logic                      rand_stall_en;
    logic [NUM_PORTS-1:0]      req_valid;
    logic [NUM_PORTS-1:0]      req_ready;
    logic [NUM_PORTS-1:0]      rsp_valid;
    mreq_req_t [NUM_PORTS-1:0] req;
    mreq_rsp_t [NUM_PORTS-1:0] rsp;

    logic        awvalid;
    logic        awready;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic        rready;
    axil_addr_t  aw;
    axil_addr_t  ar;
    axil_wdata_t w;
    axil_bresp_t b;
    axil_rdata_t r;

    mreq_rsp_t   exp_q [NUM_PORTS][$];
    logic [31:0] shadow [MEM_BYTES / 4];
    int          bus_port_q [$];

    mreq_hub i_mreq_hub (
        .clk (clk), .i_rst_n (rst_n), .i_flush (flush),
        .i_req_valid (req_valid), .i_req (req), .o_req_ready (req_ready),
        .o_rsp_valid (rsp_valid), .o_rsp (rsp),
        .o_awvalid (awvalid), .i_awready (awready), .o_aw (aw),
        .o_wvalid (wvalid), .i_wready (wready), .o_w (w),
        .i_bvalid (bvalid), .o_bready (bready), .i_b (b),
        .o_arvalid (arvalid), .i_arready (arready), .o_ar (ar),
        .i_rvalid (rvalid), .o_rready (rready), .i_r (r)
    );

    axil_mem_model i_axil_mem_model (
        .clk (clk), .i_rst_n (rst_n), .i_stall (stall),
        .i_awvalid (awvalid), .o_awready (awready), .i_aw (aw),
        .i_wvalid (wvalid), .o_wready (wready), .i_w (w),
        .o_bvalid (bvalid), .i_bready (bready), .o_b (b),
        .i_arvalid (arvalid), .o_arready (arready), .i_ar (ar),
        .o_rvalid (rvalid), .i_rready (rready), .o_r (r)
    );

    bind mreq_hub mreq_hub_chk i_mreq_hub_chk (
        .clk (clk), .i_rst_n (i_rst_n),
        .o_awvalid (o_awvalid), .i_awready (i_awready), .o_aw (o_aw),
        .o_wvalid (o_wvalid), .i_wready (i_wready), .o_w (o_w),
        .o_arvalid (o_arvalid), .i_arready (i_arready), .o_ar (o_ar),
        .o_req_ready (o_req_ready), .o_rsp_valid (o_rsp_valid)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic die();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            die();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Bit 9 of the address carries the port number
    function automatic logic [31:0] port_addr(input int p, input int word);
        return 32'((p << 9) | ((word % 128) << 2));
    endfunction

    // Expected response of a request, worked out when it is accepted
    task automatic expect_rsp(input int p, input logic wr, input logic [31:0] addr,
                              input logic [31:0] data);
        mreq_rsp_t e;
        e.err   = (addr >= MEM_BYTES);
        e.rdata = '0;
        if (!e.err) begin
            if (wr) begin
                shadow[addr[9:2]] = data;
            end else begin
                e.rdata = shadow[addr[9:2]];
            end
        end
        exp_q[p].push_back(e);
    endtask

    task automatic send_req(input int p, input logic wr, input logic [31:0] addr,
                            input logic [31:0] data);
        req_valid[p] = 1'b1;
        req[p]       = '{write: wr, addr: addr, wdata: data};
        @(posedge clk);
        while (!req_ready[p]) begin
            @(posedge clk);
        end
        #1;
        req_valid[p] = 1'b0;
        expect_rsp(p, wr, addr, data);
    endtask

    task automatic wait_idle();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
    endtask

    // Responses come back in request order per port
    always @(posedge clk) begin
        mreq_rsp_t e;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rsp_valid[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Error: response on port %0d with none outstanding", p);
                        die();
                    end
                    e = exp_q[p].pop_front();
                    check($sformatf("o_rsp[%0d].rdata", p), rsp[p].rdata, e.rdata);
                    check($sformatf("o_rsp[%0d].err", p), 32'(rsp[p].err), 32'(e.err));
                end
            end
        end
    end

    always @(posedge clk) begin
        if (awvalid && awready) begin
            bus_port_q.push_back(int'(aw.addr[9]));
        end
        if (arvalid && arready) begin
            bus_port_q.push_back(int'(ar.addr[9]));
        end
        // Every write enables all byte lanes
        if (wvalid && wready) begin
            check("o_w.strb", 32'(w.strb), 32'((1 << (`MREQ_DATA_WIDTH / 8)) - 1));
        end
        if (i_mreq_hub.i_mreq_hub_chk.fail_cnt != 0) begin
            $display("Error: an assertion on the DUT ports failed");
            die();
        end
    end

    always @(posedge clk) begin
        if (rand_stall_en) begin
            #1 stall = ($urandom_range(0, 2) == 0);
        end
    end

    initial begin
        #((TOTAL_REQS * 200 + 100) * CLK_NS);
        $display("Error: watchdog expired before the tests finished");
        die();
    end

    task automatic test_write_read();
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_req(p, 1'b1, port_addr(p, 3), 32'ha000_0000 | 32'(p));
            send_req(p, 1'b1, port_addr(p, 7), 32'hb000_0000 | 32'(p));
            send_req(p, 1'b0, port_addr(p, 3), '0);
            send_req(p, 1'b0, port_addr(p, 7), '0);
        end
        wait_idle();
    endtask

    // One request sits in the arbiter, the rest fill the queue
    task automatic test_capacity();
        int accepted;
        accepted     = 0;
        stall        = 1'b1;
        req_valid[0] = 1'b1;
        req[0]       = '{write: 1'b0, addr: port_addr(0, 20), wdata: '0};
        for (int i = 0; i < DEPTH + 4; i++) begin
            @(posedge clk);
            if (req_ready[0]) begin
                expect_rsp(0, 1'b0, req[0].addr, '0);
                accepted++;
            end
            #1;
            req[0].addr = port_addr(0, 20 + accepted);
        end
        req_valid[0] = 1'b0;
        check("accepted requests", accepted, DEPTH + 1);
        check("o_req_ready[0]", 32'(req_ready[0]), 32'd0);
        stall = 1'b0;
        wait_idle();
    endtask

    task automatic test_round_robin();
        stall = 1'b1;
        bus_port_q.delete();
        for (int i = 0; i <= DEPTH; i++) begin
            send_req(0, 1'b0, port_addr(0, 40 + i), '0);
        end
        for (int i = 0; i < DEPTH; i++) begin
            send_req(1, 1'b0, port_addr(1, 40 + i), '0);
        end
        stall = 1'b0;
        wait_idle();
        check("bus transactions", 32'(bus_port_q.size()), 32'(2 * DEPTH + 1));
        for (int i = 0; i < bus_port_q.size(); i++) begin
            check("port of bus address", 32'(bus_port_q[i]), 32'(i % 2));
        end
    endtask

    // Port 0 is full and port 1 one short of full when the flush hits
    task automatic test_flush();
        mreq_rsp_t held;
        stall = 1'b1;
        for (int i = 0; i <= DEPTH; i++) begin
            send_req(0, 1'b0, port_addr(0, 60 + i), '0);
        end
        for (int i = 0; i < DEPTH - 1; i++) begin
            send_req(1, 1'b0, port_addr(1, 60 + i), '0);
        end
        check("o_req_ready[0]", 32'(req_ready[0]), 32'd0);
        // This request meets the flush edge and is dropped
        flush        = 1'b1;
        req_valid[1] = 1'b1;
        req[1]       = '{write: 1'b0, addr: port_addr(1, 70), wdata: '0};
        next_cycle();
        flush        = 1'b0;
        req_valid[1] = 1'b0;
        held         = exp_q[0][0];
        exp_q[0].delete();
        exp_q[1].delete();
        exp_q[0].push_back(held);
        stall = 1'b0;
        wait_idle();
        repeat (20) next_cycle();
        check("o_req_ready[0]", 32'(req_ready[0]), 32'd1);
        check("o_req_ready[1]", 32'(req_ready[1]), 32'd1);
    endtask

    task automatic test_error();
        send_req(0, 1'b0, 32'h0000_1000, '0);
        send_req(1, 1'b1, 32'h0000_2004, 32'h1234_5678);
        send_req(0, 1'b0, port_addr(0, 3), '0);
        wait_idle();
    endtask

    // Each port keeps to its own half of memory so the shadow stays exact
    task automatic test_random();
        int          p;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        rand_stall_en = 1'b1;
        for (int i = 0; i < RAND_REQS; i++) begin
            p    = int'($urandom_range(0, NUM_PORTS - 1));
            wr   = ($urandom_range(0, 1) == 1);
            addr = port_addr(p, int'($urandom_range(0, 15)));
            data = $urandom;
            send_req(p, wr, addr, data);
        end
        rand_stall_en = 1'b0;
        next_cycle();
        next_cycle();
        stall = 1'b0;
        wait_idle();
    endtask

    initial begin
        void'($urandom(32'h10e9_2848));
        clk           = 1'b0;
        rst_n         = 1'b0;
        flush         = 1'b0;
        stall         = 1'b0;
        rand_stall_en = 1'b0;
        req_valid     = '0;
        req           = '0;
        for (int i = 0; i < MEM_BYTES / 4; i++) begin
            shadow[i] = 32'h5eed_0000 ^ (32'(i) << 2);
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        test_write_read();
        test_capacity();
        test_round_robin();
        test_flush();
        test_error();
        test_random();
        repeat (5) next_cycle();
        if (i_mreq_hub.i_mreq_hub_chk.fail_cnt != 0) begin
            $display("Error: an assertion on the DUT ports failed");
            die();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
